// File: all.f
+incdir+logic
logic/bp_pkg.sv
logic/bp_if.sv
logic/ghr.sv
logic/pht.sv
logic/btb.sv
logic/bp.sv
logic/branch_predictor.sv
tests/tb_branch_predictor.sv

// File: logic/bp.sv
`include "bp_defines.svh"

module bp
  import bp_pkg::*;
(
  input  logic        rst,
  // fetch
  input  addr_t       pc,
  // resolved info from decode
  input  logic        is_branch,
  input  logic        is_jump,
  input  logic        is_taken,
  input  logic        is_miss,
  input  ghr_t        last_pht_index,
  input  addr_t       inst_pc,
  input  addr_t       target,
  // storage side
  input  ghr_t        history,
  input  logic        pht_taken,
  output ghr_t        pht_index,
  bp_train_if.src     train,
  btb_lookup_if.req   lookup,
  // prediction
  output addr_t       next_pc,
  output logic        is_branch_taken
);

  addr_t seq_pc;

  // training fan-out, same strobe reaches ghr, pht and btb
  assign train.is_branch      = is_branch;
  assign train.is_jump        = is_jump;
  assign train.is_taken       = is_taken;
  assign train.last_pht_index = last_pht_index;
  assign train.inst_pc        = inst_pc;
  assign train.target         = target;

  assign lookup.pc = pc;

  // gshare: word address bits folded with history
  assign pht_index = pc[`GHR_WIDTH+1:2] ^ history;

  assign seq_pc = pc + addr_t'(4);

  // jumps are always taken once the btb knows them
  assign is_branch_taken = rst && lookup.hit && (pht_taken || lookup.is_jump);

  always_comb begin
    if (!rst) begin
      next_pc = seq_pc;
    end else if (is_miss) begin
      next_pc = target;  // decode correction wins over any prediction
    end else if (is_branch_taken) begin
      next_pc = lookup.target;
    end else begin
      next_pc = seq_pc;
    end
  end

endmodule

// File: logic/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// instruction address
`define ADDR_WIDTH 32

// global history length, also the pht index width
`define GHR_WIDTH 8

// direct mapped btb set index
`define BTB_IDX_WIDTH 6

// derived sizes
`define PHT_DEPTH (1 << `GHR_WIDTH)
`define BTB_DEPTH (1 << `BTB_IDX_WIDTH)

// upper pc bits kept as the btb tag, byte offset dropped
`define BTB_TAG_WIDTH (`ADDR_WIDTH - `BTB_IDX_WIDTH - 2)

`endif

// File: logic/bp_if.sv
// resolved branch info coming back from decode
interface bp_train_if
  import bp_pkg::*;
();

  logic  is_branch;       // one cycle strobe
  logic  is_jump;         // j / jal
  logic  is_taken;        // resolved outcome
  ghr_t  last_pht_index;  // index used when this branch was fetched
  addr_t inst_pc;         // pc of the resolved instruction
  addr_t target;          // resolved target

  modport src (
    output is_branch,
    output is_jump,
    output is_taken,
    output last_pht_index,
    output inst_pc,
    output target
  );

  modport dst (
    input is_branch,
    input is_jump,
    input is_taken,
    input last_pht_index,
    input inst_pc,
    input target
  );

endinterface

// fetch side btb lookup, answered in the same cycle
interface btb_lookup_if
  import bp_pkg::*;
();

  addr_t pc;
  logic  hit;
  logic  is_jump;
  addr_t target;

  modport req (
    output pc,
    input  hit,
    input  is_jump,
    input  target
  );

  modport rsp (
    input  pc,
    output hit,
    output is_jump,
    output target
  );

endinterface

// File: logic/bp_pkg.sv
`include "bp_defines.svh"

package bp_pkg;

  // instruction address
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // global history, doubles as pht index
  typedef logic [`GHR_WIDTH-1:0] ghr_t;

  // btb set index, pc bits just above the byte offset
  typedef logic [`BTB_IDX_WIDTH-1:0] btb_idx_t;

  // remaining upper pc bits
  typedef logic [`BTB_TAG_WIDTH-1:0] btb_tag_t;

  // 2-bit saturating counter, msb means predict taken
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } counter_t;

endpackage

// File: logic/branch_predictor.sv
module branch_predictor
  import bp_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // fetch
  input  addr_t pc,
  // from decode
  input  logic  is_branch,
  input  logic  is_jump,
  input  logic  is_taken,
  input  logic  is_miss,
  input  ghr_t  last_pht_index,
  input  addr_t inst_pc,
  input  addr_t target,
  // to pc / fetch
  output addr_t next_pc,
  output logic  is_branch_taken,
  output ghr_t  pht_index,
  output addr_t current_pc
);

  ghr_t history;
  logic pht_taken;

  bp_train_if   u_train_if ();
  btb_lookup_if u_lookup_if ();

  bp u_bp (
    .rst             (rst),
    .pc              (pc),
    .is_branch       (is_branch),
    .is_jump         (is_jump),
    .is_taken        (is_taken),
    .is_miss         (is_miss),
    .last_pht_index  (last_pht_index),
    .inst_pc         (inst_pc),
    .target          (target),
    .history         (history),
    .pht_taken       (pht_taken),
    .pht_index       (pht_index),
    .train           (u_train_if.src),
    .lookup          (u_lookup_if.req),
    .next_pc         (next_pc),
    .is_branch_taken (is_branch_taken)
  );

  // history shapes the pht index
  ghr u_ghr (
    .clk     (clk),
    .rst     (rst),
    .train   (u_train_if.dst),
    .history (history)
  );

  pht u_pht (
    .clk       (clk),
    .rst       (rst),
    .train     (u_train_if.dst),
    .pht_index (pht_index),
    .taken     (pht_taken)
  );

  btb u_btb (
    .clk    (clk),
    .rst    (rst),
    .train  (u_train_if.dst),
    .lookup (u_lookup_if.rsp)
  );

  assign current_pc = pc;  // passed on toward fetch

endmodule

// File: logic/btb.sv
`include "bp_defines.svh"

module btb
  import bp_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  bp_train_if.dst      train,
  btb_lookup_if.rsp    lookup
);

  logic [`BTB_DEPTH-1:0] valid_q;
  btb_tag_t              tag_q    [`BTB_DEPTH];
  logic                  jump_q   [`BTB_DEPTH];
  addr_t                 target_q [`BTB_DEPTH];

  btb_idx_t wr_idx;
  btb_tag_t wr_tag;
  logic     wr_en;
  btb_idx_t rd_idx;
  btb_tag_t rd_tag;

  // write side, from the resolved instruction
  assign wr_idx = train.inst_pc[`BTB_IDX_WIDTH+1:2];
  assign wr_tag = train.inst_pc[`ADDR_WIDTH-1:`BTB_IDX_WIDTH+2];
  assign wr_en  = train.is_branch | train.is_jump;

  // read side, from fetch
  assign rd_idx = lookup.pc[`BTB_IDX_WIDTH+1:2];
  assign rd_tag = lookup.pc[`ADDR_WIDTH-1:`BTB_IDX_WIDTH+2];

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // entry payload, a new pc on the same set simply replaces the old one
  always_ff @(posedge clk) begin
    if (rst && wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      jump_q[wr_idx]   <= train.is_jump;
      target_q[wr_idx] <= train.target;
    end
  end

  // valid checked first so an unwritten tag never leaks into hit
  assign lookup.hit     = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign lookup.is_jump = jump_q[rd_idx];
  assign lookup.target  = target_q[rd_idx];

  // fetch pc from bp must resolve to a clean hit once reset is done
  a_hit_known : assert property (
    @(posedge clk) disable iff (!rst)
    !$isunknown(lookup.hit)
  ) else $error("btb: hit unknown for pc %h", lookup.pc);

endmodule

// File: logic/ghr.sv
`include "bp_defines.svh"

module ghr
  import bp_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  bp_train_if.dst    train,
  output ghr_t       history
);

  ghr_t history_q;

  // only resolved branches shift in, no speculative update
  always_ff @(posedge clk) begin
    if (!rst) begin
      history_q <= '0;
    end else if (train.is_branch) begin
      history_q <= {history_q[`GHR_WIDTH-2:0], train.is_taken};  // newest outcome at bit 0
    end
  end

  assign history = history_q;

  // decode must never report an outcome without a branch strobe
  a_taken_needs_branch : assert property (
    @(posedge clk) disable iff (!rst)
    train.is_taken |-> train.is_branch
  ) else $error("ghr: is_taken high without is_branch");

endmodule

// File: logic/pht.sv
`include "bp_defines.svh"

module pht
  import bp_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  bp_train_if.dst    train,
  input  ghr_t       pht_index,
  output logic       taken
);

  counter_t cnt_q [`PHT_DEPTH];
  counter_t cnt_rd;
  counter_t cnt_wr;

  // one step toward the outcome, saturating at both ends
  function automatic counter_t step(input counter_t cur, input logic up);
    counter_t nxt;
    unique case (cur)
      strong_nt: nxt = up ? weak_nt  : strong_nt;
      weak_nt:   nxt = up ? weak_t   : strong_nt;
      weak_t:    nxt = up ? strong_t : weak_nt;
      strong_t:  nxt = up ? strong_t : weak_t;
      default:   nxt = weak_nt;
    endcase
    return nxt;
  endfunction

  assign cnt_wr = step(cnt_q[train.last_pht_index], train.is_taken);

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `PHT_DEPTH; i++) begin
        cnt_q[i] <= weak_nt;  // start just below taken
      end
    end else if (train.is_branch) begin
      cnt_q[train.last_pht_index] <= cnt_wr;
    end
  end

  // combinational read
  assign cnt_rd = cnt_q[pht_index];
  assign taken  = cnt_rd[1];

  // the indexed counter must hold one of the four states once out of reset
  a_counter_legal : assert property (
    @(posedge clk) disable iff (!rst)
    cnt_rd inside {strong_nt, weak_nt, weak_t, strong_t}
  ) else $error("pht: counter at index %0h in illegal state", pht_index);

endmodule

// File: run.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_branch_predictor

verilator --binary --timing --assert \
  --top-module "$TOP" \
  --Mdir obj_dir \
  -f all.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi

exit 0

// File: tests/tb_branch_predictor.sv
`include "bp_defines.svh"

module tb_branch_predictor
  import bp_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_cycles = 3000;  // tests take about 1200 cycles

  logic  clk = 1'b0;
  logic  rst;
  addr_t pc;
  logic  is_branch;
  logic  is_jump;
  logic  is_taken;
  logic  is_miss;
  ghr_t  last_pht_index;
  addr_t inst_pc;
  addr_t target;
  addr_t next_pc;
  logic  is_branch_taken;
  ghr_t  pht_index;
  addr_t current_pc;

  // reference model of the predictor state
  ghr_t       ref_hist;
  logic [1:0] ref_cnt    [`PHT_DEPTH];
  logic       ref_valid  [`BTB_DEPTH];
  btb_tag_t   ref_tag    [`BTB_DEPTH];
  logic       ref_jump   [`BTB_DEPTH];
  addr_t      ref_target [`BTB_DEPTH];

  logic [31:0] rng_state = 32'h7f19_7a36;
  addr_t       known_pcs [$];  // pcs with a live btb entry
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  branch_predictor u_branch_predictor (
    .clk             (clk),
    .rst             (rst),
    .pc              (pc),
    .is_branch       (is_branch),
    .is_jump         (is_jump),
    .is_taken        (is_taken),
    .is_miss         (is_miss),
    .last_pht_index  (last_pht_index),
    .inst_pc         (inst_pc),
    .target          (target),
    .next_pc         (next_pc),
    .is_branch_taken (is_branch_taken),
    .pht_index       (pht_index),
    .current_pc      (current_pc)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function addr_t random_pc();
    logic [31:0] r;
    r = next_random();
    return {r[31:2], 2'b00};  // word aligned
  endfunction

  function automatic btb_idx_t btb_set(input addr_t a);
    return a[`BTB_IDX_WIDTH+1:2];
  endfunction

  function automatic btb_tag_t btb_tag(input addr_t a);
    return a[`ADDR_WIDTH-1:`BTB_IDX_WIDTH+2];
  endfunction

  function automatic ghr_t live_index(input addr_t a);
    return a[`GHR_WIDTH+1:2] ^ ref_hist;
  endfunction

  function automatic logic model_hit(input addr_t a);
    return ref_valid[btb_set(a)] && (ref_tag[btb_set(a)] == btb_tag(a));
  endfunction

  task automatic reset_model();
    ref_hist = '0;
    for (int i = 0; i < `PHT_DEPTH; i++) begin
      ref_cnt[i] = 2'b01;  // weak not-taken
    end
    for (int i = 0; i < `BTB_DEPTH; i++) begin
      ref_valid[i] = 1'b0;
    end
  endtask

  task automatic update_model(input addr_t ipc, input addr_t tgt, input logic br,
                              input logic jmp, input logic tkn, input ghr_t lidx);
    if (br) begin
      if (tkn && ref_cnt[lidx] != 2'b11) ref_cnt[lidx] = ref_cnt[lidx] + 2'd1;
      else if (!tkn && ref_cnt[lidx] != 2'b00) ref_cnt[lidx] = ref_cnt[lidx] - 2'd1;
      ref_hist = {ref_hist[`GHR_WIDTH-2:0], tkn};
    end
    if (br || jmp) begin
      ref_valid[btb_set(ipc)]  = 1'b1;
      ref_tag[btb_set(ipc)]    = btb_tag(ipc);
      ref_jump[btb_set(ipc)]   = jmp;
      ref_target[btb_set(ipc)] = tgt;
    end
  endtask

  task automatic expect_eq(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  // one training strobe committed by the rising edge in between
  task automatic apply_update(input addr_t ipc, input addr_t tgt, input logic br,
                              input logic jmp, input logic tkn, input ghr_t lidx);
    @(negedge clk);
    is_miss        = 1'b0;
    is_branch      = br;
    is_jump        = jmp;
    is_taken       = tkn;
    last_pht_index = lidx;
    inst_pc        = ipc;
    target         = tgt;
    @(negedge clk);
    update_model(ipc, tgt, br, jmp, tkn, lidx);
    is_branch = 1'b0;
    is_jump   = 1'b0;
    is_taken  = 1'b0;
  endtask

  task automatic compare_lookup(input string name, input addr_t a, input logic miss,
                                input addr_t fix_tgt);
    ghr_t  exp_idx;
    logic  exp_taken;
    addr_t exp_next;
    @(negedge clk);
    pc      = a;
    is_miss = miss;
    target  = fix_tgt;
    #2;  // outputs settled well before the next rising edge
    exp_idx = live_index(a);
    if (!rst) begin
      exp_taken = 1'b0;
      exp_next  = a + 32'd4;
    end else begin
      exp_taken = model_hit(a) && (ref_cnt[exp_idx][1] || ref_jump[btb_set(a)]);
      if (miss) exp_next = fix_tgt;
      else if (exp_taken) exp_next = ref_target[btb_set(a)];
      else exp_next = a + 32'd4;
    end
    expect_eq(name, "next_pc", exp_next, next_pc);
    expect_eq(name, "is_branch_taken", 32'(exp_taken), 32'(is_branch_taken));
    expect_eq(name, "pht_index", 32'(exp_idx), 32'(pht_index));
    expect_eq(name, "current_pc", a, current_pc);
  endtask

  // taken strobes elsewhere until the history is all ones again
  task automatic prime_taken_history(input addr_t rpc, input ghr_t ridx);
    for (int i = 0; i < `GHR_WIDTH; i++) begin
      apply_update(rpc, rpc + 32'h100, 1'b1, 1'b0, 1'b1, ridx);
    end
  endtask

  task automatic t_reset();
    addr_t a;
    addr_t t;
    for (int i = 0; i < 20; i++) begin
      if (i == 3) begin
        @(negedge clk);
        rst = 1'b1;  // four rising edges seen with rst low
      end
      a = random_pc();
      t = random_pc();
      // reset outranks a miss held high
      compare_lookup("t_reset", a, i < 3, t);
    end
  endtask

  task automatic t_gshare_index();
    logic [31:0] r;
    for (int i = 0; i < 300; i++) begin
      r = next_random();
      apply_update(random_pc(), random_pc(), 1'b1, 1'b0, r[0], r[15:8]);
      compare_lookup("t_gshare_index", random_pc(), 1'b0, '0);
    end
  endtask

  task automatic t_counter_train();
    addr_t p;
    addr_t t;
    addr_t r;
    ghr_t  tidx;
    ghr_t  ridx;
    p    = random_pc();
    t    = random_pc();
    r    = p ^ 32'h4;  // neighbour set in the btb
    tidx = p[`GHR_WIDTH+1:2] ^ 8'hff;
    ridx = tidx ^ 8'h01;
    prime_taken_history(r, ridx);
    // taken steps keep the history at all ones so the live index stays tidx
    for (int i = 0; i < 3; i++) begin
      apply_update(p, t, 1'b1, 1'b0, 1'b1, tidx);
      compare_lookup("t_counter_train", p, 1'b0, '0);
    end
    apply_update(p, t, 1'b1, 1'b0, 1'b0, tidx);
    compare_lookup("t_counter_train", p, 1'b0, '0);
    prime_taken_history(r, ridx);
    compare_lookup("t_counter_train", p, 1'b0, '0);  // weak taken still predicts taken
    expect_eq("t_counter_train", "weak taken", 32'd1, 32'(is_branch_taken));
    apply_update(p, t, 1'b1, 1'b0, 1'b0, tidx);
    prime_taken_history(r, ridx);
    compare_lookup("t_counter_train", p, 1'b0, '0);
    expect_eq("t_counter_train", "weak not-taken", 32'd0, 32'(is_branch_taken));
    known_pcs.push_back(p);
  endtask

  task automatic t_jump();
    addr_t j;
    addr_t t;
    logic  found;
    found = 1'b0;
    j     = '0;
    for (int i = 0; i < 64; i++) begin
      j = random_pc();
      if (!ref_cnt[live_index(j)][1]) begin
        found = 1'b1;
        break;
      end
    end
    if (!found) begin
      errors++;
      $display("t_jump: no pc with a not-taken counter could be found");
    end
    t = random_pc();
    apply_update(j, t, 1'b0, 1'b1, 1'b0, '0);
    compare_lookup("t_jump", j, 1'b0, '0);
    expect_eq("t_jump", "jump taken", 32'd1, 32'(is_branch_taken));
    expect_eq("t_jump", "jump target", t, next_pc);
    known_pcs.push_back(j);
  endtask

  task automatic t_miss_override();
    addr_t a;
    for (int i = 0; i < 40; i++) begin
      if (i % 4 == 0) a = known_pcs[(i / 4) % known_pcs.size()];
      else a = random_pc();
      compare_lookup("t_miss_override", a, 1'b1, random_pc());
    end
  endtask

  task automatic t_btb_alias();
    addr_t a;
    addr_t b;
    a = random_pc();
    b = a ^ 32'h0001_0000;  // same set with another tag
    apply_update(a, random_pc(), 1'b0, 1'b1, 1'b0, '0);
    compare_lookup("t_btb_alias", a, 1'b0, '0);
    expect_eq("t_btb_alias", "first pc taken", 32'd1, 32'(is_branch_taken));
    apply_update(b, random_pc(), 1'b0, 1'b1, 1'b0, '0);
    compare_lookup("t_btb_alias", a, 1'b0, '0);
    expect_eq("t_btb_alias", "evicted taken", 32'd0, 32'(is_branch_taken));
    expect_eq("t_btb_alias", "evicted next_pc", a + 32'd4, next_pc);
    compare_lookup("t_btb_alias", b, 1'b0, '0);
  endtask

  initial begin
    rst            = 1'b0;
    pc             = '0;
    is_branch      = 1'b0;
    is_jump        = 1'b0;
    is_taken       = 1'b0;
    is_miss        = 1'b0;
    last_pht_index = '0;
    inst_pc        = '0;
    target         = '0;
    reset_model();
    t_reset();
    t_gshare_index();
    t_counter_train();
    t_jump();
    t_miss_override();
    t_btb_alias();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
